// ==== all.f ====
+incdir+common
common/rv_isa_pkg.sv
common/ooo_pkg.sv
hdl/sync_fifo.sv
dispatch/rename.sv
dispatch/dispatch.sv
hdl/backend_top.sv
test/backend_properties.sv
test/backend_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the back-end testbench with Verilator, run it and check the log.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary -sv --assert --timing -Wno-fatal \
	--top-module backend_tb -f all.f -o backend_sim
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit 1
fi

./obj_dir/backend_sim +verilator+error+limit+100 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "^TB PASSED$" "$LOG"; then
	echo "Simulation passed"
	exit 0
fi
echo "Pass message not found in $LOG"
exit 1

// ==== test/backend_tb.sv ====
/*
 * Testbench for the back end: routing, renaming, ROB order,
 * slot run-out and back-pressure, checked against a rename model.
 */

`timescale 1ns/1ps
`default_nettype none

`include "backend_settings.svh"

module backend_tb;

	localparam int TIMEOUT = 500;
	localparam int N_ROWS = 23;

	logic clk;
	logic arst_n;
	rv_isa_pkg::micro_op_t uop_in;
	logic uop_push;
	logic uop_full;
	ooo_pkg::issue_entry_t alu_issue;
	ooo_pkg::issue_entry_t bru_issue;
	ooo_pkg::issue_entry_t lsu_issue;
	logic alu_valid;
	logic bru_valid;
	logic lsu_valid;
	logic alu_pop;
	logic bru_pop;
	logic lsu_pop;
	ooo_pkg::rob_entry_t rob_head;
	logic rob_valid;
	logic commit;
	integer seed;

	// Stimulus table with the unit each row must reach.
	rv_isa_pkg::micro_op_t tbl_uop [N_ROWS];
	rv_isa_pkg::unit_e tbl_unit [N_ROWS];

	// Rename model and expected queue contents.
	logic [`RB-1:0] m_used [32];
	logic [`RB_W-1:0] m_act [32];
	ooo_pkg::issue_entry_t exp_alu [$];
	ooo_pkg::issue_entry_t exp_bru [$];
	ooo_pkg::issue_entry_t exp_lsu [$];
	ooo_pkg::rob_entry_t exp_rob [$];

	always #5 clk = ~clk;

	bind dispatch backend_properties u_props (
		.clk(clk), .arst_n(arst_n),
		.uop_empty(uop_empty), .uop_pop(uop_pop),
		.rob_full(rob_full), .rob_push(rob_push),
		.alu_full(alu_full), .alu_push(alu_push),
		.bru_full(bru_full), .bru_push(bru_push),
		.lsu_full(lsu_full), .lsu_push(lsu_push)
	);

	backend_top u_backend_top (
		.clk(clk), .arst_n(arst_n),
		.uop_in(uop_in), .uop_push(uop_push), .uop_full(uop_full),
		.alu_issue(alu_issue), .bru_issue(bru_issue), .lsu_issue(lsu_issue),
		.alu_valid(alu_valid), .bru_valid(bru_valid), .lsu_valid(lsu_valid),
		.alu_pop(alu_pop), .bru_pop(bru_pop), .lsu_pop(lsu_pop),
		.rob_head(rob_head), .rob_valid(rob_valid), .commit(commit)
	);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Checks
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	task stop_run();
		$display("TB FAILED");
		$fatal(1, "run stopped at the first error");
	endtask

	task check_issue(input string name, input ooo_pkg::issue_entry_t got,
			input ooo_pkg::issue_entry_t exp);
		if (got !== exp) begin
			$display("Fail %s: got 0x%h expected 0x%h", name, got, exp);
			stop_run();
		end
	endtask

	task check_rob(input ooo_pkg::rob_entry_t got, input ooo_pkg::rob_entry_t exp);
		if (got !== exp) begin
			$display("Fail rob_head: got 0x%h expected 0x%h", got, exp);
			stop_run();
		end
	endtask

	task check_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("Fail %s: got 0x%h expected 0x%h", name, got, exp);
			stop_run();
		end
	endtask

	task timeout_error(input string what);
		$display("Timeout while waiting for %s", what);
		stop_run();
	endtask

	task check_idle();
		check_bit("alu_valid", alu_valid, 1'b0);
		check_bit("bru_valid", bru_valid, 1'b0);
		check_bit("lsu_valid", lsu_valid, 1'b0);
		check_bit("rob_valid", rob_valid, 1'b0);
		check_bit("uop_full", uop_full, 1'b0);
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Table and reference model
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	task set_row(input int idx, input rv_isa_pkg::uop_op_e op, input logic [4:0] rd,
			input logic [4:0] rs1, input logic [4:0] rs2, input rv_isa_pkg::unit_e unit);
		tbl_uop[idx] = '{op: op, pc: 32'h0000_1000 + 32'(idx * 4),
			imm: 32'hA5A5_0000 ^ 32'(idx * 257), rd: rd, rs1: rs1, rs2: rs2};
		tbl_unit[idx] = unit;
	endtask

	task fill_table();
		// Routing and tags, with reads of registers renamed just before.
		set_row(0, rv_isa_pkg::OP_ADD, 5'd1, 5'd0, 5'd0, rv_isa_pkg::UNIT_ALU);
		set_row(1, rv_isa_pkg::OP_LW, 5'd2, 5'd1, 5'd0, rv_isa_pkg::UNIT_LSU);
		set_row(2, rv_isa_pkg::OP_SUB, 5'd1, 5'd1, 5'd2, rv_isa_pkg::UNIT_ALU);
		set_row(3, rv_isa_pkg::OP_MRET, 5'd0, 5'd0, 5'd0, rv_isa_pkg::UNIT_NONE);
		set_row(4, rv_isa_pkg::OP_BEQ, 5'd0, 5'd1, 5'd2, rv_isa_pkg::UNIT_BRU);
		set_row(5, rv_isa_pkg::OP_SW, 5'd0, 5'd2, 5'd1, rv_isa_pkg::UNIT_LSU);
		set_row(6, rv_isa_pkg::OP_EBREAK, 5'd0, 5'd0, 5'd0, rv_isa_pkg::UNIT_NONE);
		set_row(7, rv_isa_pkg::OP_XOR, 5'd3, 5'd1, 5'd3, rv_isa_pkg::UNIT_ALU);
		set_row(8, rv_isa_pkg::OP_BLT, 5'd0, 5'd3, 5'd1, rv_isa_pkg::UNIT_BRU);
		set_row(9, rv_isa_pkg::OP_FENCE, 5'd0, 5'd0, 5'd0, rv_isa_pkg::UNIT_LSU);
		// Five writers of x5 for the run-out case.
		set_row(10, rv_isa_pkg::OP_ADD, 5'd5, 5'd1, 5'd0, rv_isa_pkg::UNIT_ALU);
		set_row(11, rv_isa_pkg::OP_LW, 5'd5, 5'd5, 5'd0, rv_isa_pkg::UNIT_LSU);
		set_row(12, rv_isa_pkg::OP_ADD, 5'd5, 5'd5, 5'd2, rv_isa_pkg::UNIT_ALU);
		set_row(13, rv_isa_pkg::OP_LW, 5'd5, 5'd5, 5'd0, rv_isa_pkg::UNIT_LSU);
		set_row(14, rv_isa_pkg::OP_ADD, 5'd5, 5'd5, 5'd3, rv_isa_pkg::UNIT_ALU);
		// ALU chain for back-pressure; one writer per register.
		set_row(15, rv_isa_pkg::OP_ADD, 5'd10, 5'd5, 5'd1, rv_isa_pkg::UNIT_ALU);
		set_row(16, rv_isa_pkg::OP_SUB, 5'd11, 5'd10, 5'd3, rv_isa_pkg::UNIT_ALU);
		set_row(17, rv_isa_pkg::OP_AND, 5'd12, 5'd11, 5'd10, rv_isa_pkg::UNIT_ALU);
		set_row(18, rv_isa_pkg::OP_OR, 5'd13, 5'd12, 5'd2, rv_isa_pkg::UNIT_ALU);
		set_row(19, rv_isa_pkg::OP_XOR, 5'd14, 5'd13, 5'd12, rv_isa_pkg::UNIT_ALU);
		set_row(20, rv_isa_pkg::OP_SLT, 5'd15, 5'd14, 5'd5, rv_isa_pkg::UNIT_ALU);
		set_row(21, rv_isa_pkg::OP_ADD, 5'd16, 5'd15, 5'd14, rv_isa_pkg::UNIT_ALU);
		set_row(22, rv_isa_pkg::OP_SUB, 5'd17, 5'd16, 5'd1, rv_isa_pkg::UNIT_ALU);
	endtask

	function automatic logic writes_rd_of(input rv_isa_pkg::uop_op_e op);
		case (op)
			rv_isa_pkg::OP_ADD, rv_isa_pkg::OP_SUB, rv_isa_pkg::OP_AND,
			rv_isa_pkg::OP_OR, rv_isa_pkg::OP_XOR, rv_isa_pkg::OP_SLT,
			rv_isa_pkg::OP_LW: return 1'b1;
			default: return 1'b0;
		endcase
	endfunction

	// Model one dispatch in program order and queue the expected entries.
	task predict(input int idx);
		rv_isa_pkg::micro_op_t u;
		ooo_pkg::issue_entry_t ie;
		ooo_pkg::rob_entry_t re;
		logic wr;
		int slot;
		u = tbl_uop[idx];
		wr = writes_rd_of(u.op);
		slot = -1;
		if (tbl_unit[idx] != rv_isa_pkg::UNIT_NONE) begin
			ie.op = u.op;
			ie.pc = u.pc;
			ie.imm = u.imm;
			ie.rs1_tag = '{arch: u.rs1, slot: m_act[u.rs1]};
			ie.rs2_tag = '{arch: u.rs2, slot: m_act[u.rs2]};
			ie.rd_tag = '0;
			if (wr) begin
				for (int s = `RB - 1; s >= 0; s--) begin
					if (!m_used[u.rd][s])
						slot = s;
				end
				if (slot < 0) begin
					$display("Model has no free slot for register %0d", u.rd);
					stop_run();
				end
				ie.rd_tag = '{arch: u.rd, slot: slot[`RB_W-1:0]};
				m_used[u.rd][slot] = 1'b1;
				m_act[u.rd] = slot[`RB_W-1:0];
			end
			re = '{pc: u.pc, unit: tbl_unit[idx], rd_valid: wr, rd_tag: ie.rd_tag,
				is_branch: tbl_unit[idx] == rv_isa_pkg::UNIT_BRU,
				is_store: u.op == rv_isa_pkg::OP_SW};
			case (tbl_unit[idx])
				rv_isa_pkg::UNIT_ALU: exp_alu.push_back(ie);
				rv_isa_pkg::UNIT_BRU: exp_bru.push_back(ie);
				default: exp_lsu.push_back(ie);
			endcase
			exp_rob.push_back(re);
		end
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Drivers
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	task clear_pops();
		alu_pop = 1'b0;
		bru_pop = 1'b0;
		lsu_pop = 1'b0;
		commit = 1'b0;
	endtask

	function automatic bit allow_pop(input bit stall);
		if (!stall)
			return 1'b1;
		return ($random(seed) & 3) != 0;
	endfunction

	task push_uop(input int idx);
		int waited;
		waited = 0;
		@(negedge clk);
		while (uop_full) begin
			waited++;
			if (waited > TIMEOUT)
				timeout_error("room in the instruction queue");
			@(negedge clk);
		end
		uop_in = tbl_uop[idx];
		uop_push = 1'b1;
		@(negedge clk);
		uop_push = 1'b0;
	endtask

	task wait_uop_full();
		int waited;
		waited = 0;
		while (!uop_full) begin
			waited++;
			if (waited > TIMEOUT)
				timeout_error("the instruction queue to fill");
			@(negedge clk);
		end
	endtask

	// Check the ROB head against the model and release its slot.
	task commit_head();
		ooo_pkg::rob_entry_t e;
		e = exp_rob.pop_front();
		check_rob(rob_head, e);
		if (e.rd_valid)
			m_used[e.rd_tag.arch][e.rd_tag.slot] = 1'b0;
		commit = 1'b1;
	endtask

	task commit_one();
		int waited;
		waited = 0;
		@(negedge clk);
		while (!rob_valid) begin
			waited++;
			if (waited > TIMEOUT)
				timeout_error("a ROB entry to commit");
			@(negedge clk);
		end
		commit_head();
		@(negedge clk);
		commit = 1'b0;
	endtask

	task drain(input bit pop_issue, input bit do_commit, input bit stall);
		int cycles;
		cycles = 0;
		while ((pop_issue && (exp_alu.size() + exp_bru.size() + exp_lsu.size()) > 0) ||
				(do_commit && exp_rob.size() > 0)) begin
			@(negedge clk);
			clear_pops();
			cycles++;
			if (cycles > TIMEOUT)
				timeout_error("the issue queues and the ROB to drain");
			if (pop_issue && exp_alu.size() > 0 && alu_valid && allow_pop(stall)) begin
				check_issue("alu_issue", alu_issue, exp_alu.pop_front());
				alu_pop = 1'b1;
			end
			if (pop_issue && exp_bru.size() > 0 && bru_valid && allow_pop(stall)) begin
				check_issue("bru_issue", bru_issue, exp_bru.pop_front());
				bru_pop = 1'b1;
			end
			if (pop_issue && exp_lsu.size() > 0 && lsu_valid && allow_pop(stall)) begin
				check_issue("lsu_issue", lsu_issue, exp_lsu.pop_front());
				lsu_pop = 1'b1;
			end
			if (do_commit && exp_rob.size() > 0 && rob_valid && allow_pop(stall))
				commit_head();
		end
		@(negedge clk);
		clear_pops();
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Sequence
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	initial begin
		seed = 13110;
		clk = 1'b0;
		arst_n = 1'b0;
		uop_push = 1'b0;
		uop_in = '0;
		clear_pops();
		fill_table();
		for (int r = 0; r < 32; r++) begin
			m_used[r] = '0;
			m_act[r] = '0;
		end
		repeat (3) @(posedge clk);
		@(negedge clk);
		arst_n = 1'b1;
		@(negedge clk);
		check_idle();

		// Routing, tags and ROB order; commits only after all dispatched.
		for (int i = 0; i < 10; i++) begin
			push_uop(i);
			predict(i);
		end
		drain(1'b1, 1'b0, 1'b0);
		drain(1'b0, 1'b1, 1'b0);
		check_idle();

		// Fifth writer of x5 waits until a slot is freed.
		for (int i = 10; i < 15; i++)
			push_uop(i);
		for (int i = 10; i < 14; i++)
			predict(i);
		drain(1'b1, 1'b0, 1'b0);
		repeat (10) begin
			@(negedge clk);
			check_bit("alu_valid", alu_valid, 1'b0);
		end
		commit_one();
		predict(14);
		drain(1'b1, 1'b0, 1'b0);
		drain(1'b0, 1'b1, 1'b0);
		check_idle();

		// ALU queue left unpopped until the instruction queue fills.
		for (int i = 15; i < N_ROWS; i++) begin
			push_uop(i);
			predict(i);
		end
		wait_uop_full();
		// The blocked head stays put, so the instruction queue stays full.
		repeat (3) begin
			@(negedge clk);
			check_bit("uop_full", uop_full, 1'b1);
		end
		drain(1'b1, 1'b1, 1'b1);
		check_idle();

		if (u_backend_top.u_dispatch.u_props.violations != 0) begin
			$display("Dispatch handshake assertions failed during the run");
			stop_run();
		end else begin
			$display("TB PASSED");
			$finish;
		end
	end

endmodule

`default_nettype wire

// ==== test/backend_properties.sv ====
/*
 * Dispatch handshake rules, bound into the dispatch stage.
 */

`timescale 1ns/1ps
`default_nettype none

module backend_properties (
	input wire logic clk,
	input wire logic arst_n,
	input wire logic uop_empty,
	input wire logic uop_pop,
	input wire logic rob_full,
	input wire logic rob_push,
	input wire logic alu_full,
	input wire logic alu_push,
	input wire logic bru_full,
	input wire logic bru_push,
	input wire logic lsu_full,
	input wire logic lsu_push
);

	// Number of failed rules, read by the testbench at the end.
	int violations = 0;

	a_one_unit_push: assert property (@(posedge clk) disable iff (!arst_n)
		$onehot0({alu_push, bru_push, lsu_push}))
	else begin
		violations = violations + 1;
		$error("more than one issue queue pushed in one cycle");
	end

	a_push_not_full: assert property (@(posedge clk) disable iff (!arst_n)
		!(alu_push && alu_full) && !(bru_push && bru_full) &&
		!(lsu_push && lsu_full) && !(rob_push && rob_full))
	else begin
		violations = violations + 1;
		$error("push into a full queue");
	end

	a_rob_with_unit: assert property (@(posedge clk) disable iff (!arst_n)
		rob_push == (alu_push | bru_push | lsu_push))
	else begin
		violations = violations + 1;
		$error("ROB push does not match the issue queue pushes");
	end

	a_pop_not_empty: assert property (@(posedge clk) disable iff (!arst_n)
		!(uop_pop && uop_empty))
	else begin
		violations = violations + 1;
		$error("instruction queue popped while empty");
	end

endmodule

`default_nettype wire

// ==== hdl/backend_top.sv ====
/*
 * Back-end top: instruction queue, dispatch, three issue queues and the ROB.
 */

`timescale 1ns/1ps
`default_nettype none

`include "backend_settings.svh"

module backend_top (
	input wire logic clk,
	input wire logic arst_n,
	input wire rv_isa_pkg::micro_op_t uop_in,
	input wire logic uop_push,
	output logic uop_full,
	output ooo_pkg::issue_entry_t alu_issue,
	output ooo_pkg::issue_entry_t bru_issue,
	output ooo_pkg::issue_entry_t lsu_issue,
	output logic alu_valid,
	output logic bru_valid,
	output logic lsu_valid,
	input wire logic alu_pop,
	input wire logic bru_pop,
	input wire logic lsu_pop,
	output ooo_pkg::rob_entry_t rob_head,
	output logic rob_valid,
	input wire logic commit
);

	rv_isa_pkg::micro_op_t uop_head;
	logic uop_empty;
	logic uop_pop;
	logic rob_push;
	logic rob_full;
	logic rob_empty;
	ooo_pkg::rob_entry_t rob_entry;
	ooo_pkg::issue_entry_t issue_entry;
	logic alu_push, alu_full, alu_empty;
	logic bru_push, bru_full, bru_empty;
	logic lsu_push, lsu_full, lsu_empty;
	logic free_valid;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Queues
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	sync_fifo #(.DEPTH(`UOP_DEPTH), .T(rv_isa_pkg::micro_op_t)) u_uop_q (
		.clk(clk), .arst_n(arst_n),
		.push(uop_push), .din(uop_in), .full(uop_full),
		.pop(uop_pop), .dout(uop_head), .empty(uop_empty)
	);

	sync_fifo #(.DEPTH(`ISSUE_DEPTH), .T(ooo_pkg::issue_entry_t)) u_alu_q (
		.clk(clk), .arst_n(arst_n),
		.push(alu_push), .din(issue_entry), .full(alu_full),
		.pop(alu_pop), .dout(alu_issue), .empty(alu_empty)
	);

	sync_fifo #(.DEPTH(`ISSUE_DEPTH), .T(ooo_pkg::issue_entry_t)) u_bru_q (
		.clk(clk), .arst_n(arst_n),
		.push(bru_push), .din(issue_entry), .full(bru_full),
		.pop(bru_pop), .dout(bru_issue), .empty(bru_empty)
	);

	sync_fifo #(.DEPTH(`ISSUE_DEPTH), .T(ooo_pkg::issue_entry_t)) u_lsu_q (
		.clk(clk), .arst_n(arst_n),
		.push(lsu_push), .din(issue_entry), .full(lsu_full),
		.pop(lsu_pop), .dout(lsu_issue), .empty(lsu_empty)
	);

	// Commit pops the ROB head.
	sync_fifo #(.DEPTH(`ROB_DEPTH), .T(ooo_pkg::rob_entry_t)) u_rob (
		.clk(clk), .arst_n(arst_n),
		.push(rob_push), .din(rob_entry), .full(rob_full),
		.pop(commit), .dout(rob_head), .empty(rob_empty)
	);

	assign alu_valid = ~alu_empty;
	assign bru_valid = ~bru_empty;
	assign lsu_valid = ~lsu_empty;
	assign rob_valid = ~rob_empty;

	// Committing head releases its rename slot.
	assign free_valid = commit & rob_head.rd_valid;

	dispatch u_dispatch (
		.clk(clk), .arst_n(arst_n),
		.uop(uop_head), .uop_empty(uop_empty), .uop_pop(uop_pop),
		.rob_full(rob_full), .rob_push(rob_push), .rob_entry(rob_entry),
		.alu_full(alu_full), .alu_push(alu_push),
		.bru_full(bru_full), .bru_push(bru_push),
		.lsu_full(lsu_full), .lsu_push(lsu_push),
		.issue_entry(issue_entry),
		.free_valid(free_valid), .free_tag(rob_head.rd_tag)
	);

endmodule

`default_nettype wire

// ==== dispatch/dispatch.sv ====
/*
 * Dispatch stage: routes the head micro-op to its issue queue and the ROB.
 * Renames registers on the way and drops mret and ebreak.
 */

`timescale 1ns/1ps
`default_nettype none

module dispatch (
	input wire logic clk,
	input wire logic arst_n,
	input wire rv_isa_pkg::micro_op_t uop,
	input wire logic uop_empty,
	output logic uop_pop,
	input wire logic rob_full,
	output logic rob_push,
	output ooo_pkg::rob_entry_t rob_entry,
	input wire logic alu_full,
	output logic alu_push,
	input wire logic bru_full,
	output logic bru_push,
	input wire logic lsu_full,
	output logic lsu_push,
	output ooo_pkg::issue_entry_t issue_entry,
	input wire logic free_valid,
	input wire ooo_pkg::rn_tag_t free_tag
);

	rv_isa_pkg::unit_e unit;
	logic writes_rd;
	logic is_branch;
	logic is_store;
	logic drop;
	logic unit_full;
	logic dispatch_ok;
	logic rd_req;
	logic rd_run_out;
	ooo_pkg::rn_tag_t rs1_tag;
	ooo_pkg::rn_tag_t rs2_tag;
	ooo_pkg::rn_tag_t rd_tag;
	ooo_pkg::rn_tag_t rd_tag_out;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Opcode decode
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_comb begin
		unit = rv_isa_pkg::UNIT_NONE;
		writes_rd = 1'b0;
		is_branch = 1'b0;
		is_store = 1'b0;
		drop = 1'b0;
		case (uop.op)
			rv_isa_pkg::OP_ADD, rv_isa_pkg::OP_SUB, rv_isa_pkg::OP_AND,
			rv_isa_pkg::OP_OR, rv_isa_pkg::OP_XOR, rv_isa_pkg::OP_SLT: begin
				unit = rv_isa_pkg::UNIT_ALU;
				writes_rd = 1'b1;
			end
			rv_isa_pkg::OP_BEQ, rv_isa_pkg::OP_BNE, rv_isa_pkg::OP_BLT: begin
				unit = rv_isa_pkg::UNIT_BRU;
				is_branch = 1'b1;
			end
			rv_isa_pkg::OP_LW: begin
				unit = rv_isa_pkg::UNIT_LSU;
				writes_rd = 1'b1;
			end
			rv_isa_pkg::OP_SW: begin
				unit = rv_isa_pkg::UNIT_LSU;
				is_store = 1'b1;
			end
			rv_isa_pkg::OP_FENCE: unit = rv_isa_pkg::UNIT_LSU;
			// mret, ebreak and unknown codes are not implemented here.
			default: drop = 1'b1;
		endcase
	end

	always_comb begin
		case (unit)
			rv_isa_pkg::UNIT_ALU: unit_full = alu_full;
			rv_isa_pkg::UNIT_BRU: unit_full = bru_full;
			rv_isa_pkg::UNIT_LSU: unit_full = lsu_full;
			default: unit_full = 1'b1;
		endcase
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Dispatch condition and pushes
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	assign dispatch_ok = ~uop_empty & ~rob_full & ~unit_full & ~(writes_rd & rd_run_out);

	assign alu_push = dispatch_ok & (unit == rv_isa_pkg::UNIT_ALU);
	assign bru_push = dispatch_ok & (unit == rv_isa_pkg::UNIT_BRU);
	assign lsu_push = dispatch_ok & (unit == rv_isa_pkg::UNIT_LSU);
	assign rob_push = alu_push | bru_push | lsu_push;
	// Dropped ops leave the queue without touching ROB or issue queues.
	assign uop_pop = rob_push | (drop & ~uop_empty);

	// Slot is taken only when the op really leaves.
	assign rd_req = rob_push & writes_rd;

	// No destination tag for ops that do not write rd.
	assign rd_tag_out = writes_rd ? rd_tag : '0;

	assign issue_entry = '{
		op: uop.op,
		pc: uop.pc,
		imm: uop.imm,
		rd_tag: rd_tag_out,
		rs1_tag: rs1_tag,
		rs2_tag: rs2_tag
	};

	assign rob_entry = '{
		pc: uop.pc,
		unit: unit,
		rd_valid: writes_rd,
		rd_tag: rd_tag_out,
		is_branch: is_branch,
		is_store: is_store
	};

	rename u_rename (
		.clk(clk),
		.arst_n(arst_n),
		.rs1(uop.rs1),
		.rs2(uop.rs2),
		.rd(uop.rd),
		.rd_req(rd_req),
		.rs1_tag(rs1_tag),
		.rs2_tag(rs2_tag),
		.rd_tag(rd_tag),
		.rd_run_out(rd_run_out),
		.free_valid(free_valid),
		.free_tag(free_tag)
	);

endmodule

`default_nettype wire

// ==== dispatch/rename.sv ====
/*
 * Register rename with a fixed set of slots per architectural register.
 * Gives source tags from the active slot and allocates destination slots.
 */

`timescale 1ns/1ps
`default_nettype none

`include "backend_settings.svh"

module rename (
	input wire logic clk,
	input wire logic arst_n,
	input wire logic [4:0] rs1,
	input wire logic [4:0] rs2,
	input wire logic [4:0] rd,
	input wire logic rd_req,
	output ooo_pkg::rn_tag_t rs1_tag,
	output ooo_pkg::rn_tag_t rs2_tag,
	output ooo_pkg::rn_tag_t rd_tag,
	output logic rd_run_out,
	input wire logic free_valid,
	input wire ooo_pkg::rn_tag_t free_tag
);

	localparam int ARCH_REGS = 32;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Slot tables
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// One bit per slot, set while the slot holds an uncommitted result.
	logic [`RB-1:0] used [ARCH_REGS];
	// Slot that holds the youngest value of each register.
	logic [`RB_W-1:0] act [ARCH_REGS];
	logic [`RB_W-1:0] free_slot;

	// Lowest free slot of rd. The loop runs downwards so the lowest wins.
	always_comb begin
		free_slot = '0;
		for (int i = `RB - 1; i >= 0; i--) begin
			if (!used[rd][i])
				free_slot = `RB_W'(i);
		end
	end

	assign rd_run_out = &used[rd];

	// Sources see the active slot from before this edge.
	assign rs1_tag = '{arch: rs1, slot: act[rs1]};
	assign rs2_tag = '{arch: rs2, slot: act[rs2]};
	assign rd_tag = '{arch: rd, slot: free_slot};

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Allocate and free
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int r = 0; r < ARCH_REGS; r++) begin
				used[r] <= '0;
				act[r] <= '0;
			end
		end else begin
			// Commit releases a slot; the active pointer stays where it is.
			if (free_valid)
				used[free_tag.arch][free_tag.slot] <= 1'b0;
			// A free slot is never the one being released, so no clash.
			if (rd_req) begin
				used[rd][free_slot] <= 1'b1;
				act[rd] <= free_slot;
			end
		end
	end

endmodule

`default_nettype wire

// ==== hdl/sync_fifo.sv ====
/*
 * Synchronous queue with push/full and pop/empty handshakes.
 * The front entry is shown on dout while the queue is not empty.
 */

`timescale 1ns/1ps
`default_nettype none

module sync_fifo #(
	parameter int DEPTH = 4,
	parameter type T = logic [7:0]
) (
	input wire logic clk,
	input wire logic arst_n,
	input wire logic push,
	input wire T din,
	output logic full,
	input wire logic pop,
	output T dout,
	output logic empty
);

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	T mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic do_push;
	logic do_pop;

	assign do_push = push & ~full;
	assign do_pop = pop & ~empty;

	// Storage.
	always_ff @(posedge clk) begin
		if (do_push)
			mem[wr_ptr] <= din;
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (do_push)
				wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			// Simultaneous push and pop leave the count unchanged.
			case ({do_push, do_pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	assign full = (count == CNT_W'(DEPTH));
	assign empty = (count == '0);
	assign dout = mem[rd_ptr];

endmodule

`default_nettype wire

// ==== common/ooo_pkg.sv ====
/*
 * Out-of-order bookkeeping types: rename tags, issue and ROB entries.
 */

`default_nettype none

`include "backend_settings.svh"

package ooo_pkg;

	// Physical tag. The architectural register plus one of its rename slots.
	typedef struct packed {
		logic [4:0] arch;
		logic [`RB_W-1:0] slot;
	} rn_tag_t;

	// Entry of the ALU, BRU and LSU issue queues.
	typedef struct packed {
		rv_isa_pkg::uop_op_e op;
		logic [`XLEN-1:0] pc;
		logic [`XLEN-1:0] imm;
		rn_tag_t rd_tag;
		rn_tag_t rs1_tag;
		rn_tag_t rs2_tag;
	} issue_entry_t;

	// Reorder buffer entry, kept in program order.
	typedef struct packed {
		logic [`XLEN-1:0] pc;
		rv_isa_pkg::unit_e unit;
		logic rd_valid;
		// Slot that is released at commit.
		rn_tag_t rd_tag;
		logic is_branch;
		logic is_store;
	} rob_entry_t;

endpackage

`default_nettype wire

// ==== common/rv_isa_pkg.sv ====
/*
 * RV32 micro-op types: opcodes, target units and the decoded micro-op.
 */

`default_nettype none

`include "backend_settings.svh"

package rv_isa_pkg;

	// Micro-op opcodes as delivered by the decoder.
	typedef enum logic [3:0] {
		OP_ADD,
		OP_SUB,
		OP_AND,
		OP_OR,
		OP_XOR,
		OP_SLT,
		OP_BEQ,
		OP_BNE,
		OP_BLT,
		OP_LW,
		OP_SW,
		OP_FENCE,
		OP_MRET,
		OP_EBREAK
	} uop_op_e;

	// Issue target. UNIT_NONE marks ops that are dropped.
	typedef enum logic [1:0] {
		UNIT_ALU,
		UNIT_BRU,
		UNIT_LSU,
		UNIT_NONE
	} unit_e;

	// Decoded micro-op in the instruction queue.
	typedef struct packed {
		uop_op_e op;
		logic [`XLEN-1:0] pc;
		logic [`XLEN-1:0] imm;
		logic [4:0] rd;
		logic [4:0] rs1;
		logic [4:0] rs2;
	} micro_op_t;

endpackage

`default_nettype wire

// ==== common/backend_settings.svh ====
/*
 * Back-end settings: data width, rename slots and queue depths.
 */

`ifndef BACKEND_SETTINGS_SVH
`define BACKEND_SETTINGS_SVH

// Data width of pc and imm.
`define XLEN 32

// Rename slots per architectural register and the slot index width.
`define RB 4
`define RB_W 2

// Queue depths.
`define UOP_DEPTH 4
`define ISSUE_DEPTH 4
`define ROB_DEPTH 8

`endif
